// ==== include/cce_decode_config.svh ====
`ifndef CCE_DECODE_CONFIG_SVH
`define CCE_DECODE_CONFIG_SVH

// microcode PC and instruction word
`define CCE_PC_WIDTH 8
`define CCE_INST_WIDTH 32

// general purpose registers
`define CCE_GPR_NUM 8
`define CCE_GPR_SEL_WIDTH 3

// flag register file
`define CCE_FLAG_NUM 8

// operand select field in the instruction formats
`define CCE_OPD_WIDTH 4

// immediates
`define CCE_IMM16_WIDTH 16
`define CCE_IMM8_WIDTH 8

`endif

// ==== src/cce_decode_pkg.sv ====
`include "cce_decode_config.svh"

package cce_decode_pkg;

  // major op
  typedef enum logic [2:0] {
    e_op_alu      = 3'd0,
    e_op_branch   = 3'd1,
    e_op_reg_data = 3'd2,
    e_op_flag     = 3'd3
  } op_e;

  // minor ops, one encoding space per major op
  typedef enum logic [3:0] {
    e_add_op, e_sub_op, e_lsh_op, e_rsh_op, e_and_op, e_or_op, e_xor_op,
    e_neg_op, e_addi_op, e_subi_op, e_lshi_op, e_rshi_op, e_not_op
  } alu_minor_e;

  typedef enum logic [3:0] {
    e_beq_op, e_bne_op, e_blt_op, e_ble_op, e_beqi_op
  } branch_minor_e;

  typedef enum logic [3:0] {
    e_mov_op, e_movfg_op, e_movgf_op, e_movi_op
  } reg_data_minor_e;

  // flag branches live in the flag class
  typedef enum logic [3:0] {
    e_sf_op, e_andf_op, e_orf_op, e_nandf_op, e_norf_op, e_notf_op,
    e_bf_op, e_bfz_op, e_bfnz_op, e_bfnot_op
  } flag_minor_e;

  typedef union packed {
    alu_minor_e      alu_minor_op;
    branch_minor_e   branch_minor_op;
    reg_data_minor_e reg_data_minor_op;
    flag_minor_e     flag_minor_op;
  } minor_op_u;

  // op, minor op and the two hint bits sit above the format field
  localparam int inst_type_width_lp = `CCE_INST_WIDTH - $bits(op_e) - $bits(minor_op_u) - 2;
  // target takes the top of the format field, flag mask gets what is left
  localparam int bf_imm_width_lp = inst_type_width_lp - `CCE_PC_WIDTH;

  // dst / src_a always at the bottom, branch target always at the top
  typedef struct packed {
    logic [inst_type_width_lp-3*`CCE_OPD_WIDTH-1:0] pad;
    logic [`CCE_OPD_WIDTH-1:0]                      src_b;
    logic [`CCE_OPD_WIDTH-1:0]                      src_a;
    logic [`CCE_OPD_WIDTH-1:0]                      dst;
  } rtype_t;

  typedef struct packed {
    logic [inst_type_width_lp-`CCE_IMM16_WIDTH-`CCE_OPD_WIDTH-1:0] pad;
    logic [`CCE_IMM16_WIDTH-1:0]                                   imm;
    logic [`CCE_OPD_WIDTH-1:0]                                     dst;
  } itype_t;

  typedef struct packed {
    logic [`CCE_PC_WIDTH-1:0]                                       target;
    logic [inst_type_width_lp-`CCE_PC_WIDTH-2*`CCE_OPD_WIDTH-1:0] pad;
    logic [`CCE_OPD_WIDTH-1:0]                                      src_b;
    logic [`CCE_OPD_WIDTH-1:0]                                      src_a;
  } btype_t;

  typedef struct packed {
    logic [`CCE_PC_WIDTH-1:0]                                             target;
    logic [inst_type_width_lp-`CCE_PC_WIDTH-`CCE_IMM8_WIDTH-`CCE_OPD_WIDTH-1:0] pad;
    logic [`CCE_IMM8_WIDTH-1:0]                                           imm;
    logic [`CCE_OPD_WIDTH-1:0]                                            src_a;
  } bitype_t;

  // mask one bit short of imm16, upper imm bit decodes as zero
  typedef struct packed {
    logic [`CCE_PC_WIDTH-1:0]   target;
    logic [bf_imm_width_lp-1:0] imm;
  } bftype_t;

  typedef union packed {
    rtype_t  rtype;
    itype_t  itype;
    btype_t  btype;
    bitype_t bitype;
    bftype_t bftype;
  } inst_type_u;

  typedef struct packed {
    op_e        op;
    minor_op_u  minor_op;
    logic       branch;
    logic       predict_taken;
    inst_type_u type_u;
  } cce_inst_t;

  typedef enum logic [3:0] {
    e_alu_add, e_alu_sub, e_alu_lsh, e_alu_rsh, e_alu_and, e_alu_or,
    e_alu_xor, e_alu_neg, e_alu_not, e_alu_nand, e_alu_nor
  } alu_op_e;

  typedef enum logic [1:0] {
    e_branch_eq, e_branch_neq, e_branch_lt, e_branch_le
  } branch_op_e;

  typedef enum logic [2:0] {
    e_src_sel_none, e_src_sel_gpr, e_src_sel_imm, e_src_sel_flag,
    e_src_sel_zero, e_src_sel_flags_mask
  } src_sel_e;

  typedef enum logic [1:0] {
    e_dst_sel_none, e_dst_sel_gpr, e_dst_sel_flag
  } dst_sel_e;

  typedef struct packed {
    alu_op_e                     alu_op;
    branch_op_e                  branch_op;
    src_sel_e                    src_a_sel;
    logic [`CCE_OPD_WIDTH-1:0]   src_a;
    src_sel_e                    src_b_sel;
    logic [`CCE_OPD_WIDTH-1:0]   src_b;
    dst_sel_e                    dst_sel;
    logic [`CCE_OPD_WIDTH-1:0]   dst;
    logic [`CCE_IMM16_WIDTH-1:0] imm;
    logic [`CCE_PC_WIDTH-1:0]    branch_target;
  } decode_fields_t;

  typedef struct packed {
    logic                     v;
    logic                     branch;
    logic                     predict_taken;
    op_e                      op;
    decode_fields_t           fields;
    logic [`CCE_GPR_NUM-1:0]  gpr_w_v;
    logic [`CCE_FLAG_NUM-1:0] flag_w_v;
  } decoded_inst_t;

endpackage

// ==== src/cce_inst_stage.sv ====
`include "cce_decode_config.svh"

module cce_inst_stage (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  cce_decode_pkg::cce_inst_t    inst_i,
  input  logic [`CCE_PC_WIDTH-1:0]     pc_i,
  input  logic                         inst_v_i,
  input  logic                         stall_i,
  input  logic                         mispredict_i,
  output cce_decode_pkg::cce_inst_t    inst_o,
  output logic [`CCE_PC_WIDTH-1:0]     pc_o,
  output logic                         inst_v_o
);

  cce_decode_pkg::cce_inst_t inst_r;
  logic [`CCE_PC_WIDTH-1:0]  pc_r;
  logic                      inst_v_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inst_r   <= '0;
      pc_r     <= '0;
      inst_v_r <= 1'b0;
    end else if (!stall_i) begin
      inst_r <= inst_i;
      pc_r   <= pc_i;
      // fetch is redirected on a mispredict, so the word it hands over is dropped
      inst_v_r <= inst_v_i & ~mispredict_i;
    end
    // stalled: everything holds and the same instruction replays next cycle
  end

  assign inst_o   = inst_r;
  assign pc_o     = pc_r;
  assign inst_v_o = inst_v_r;

endmodule

// ==== src/cce_alu_mov_decode.sv ====
module cce_alu_mov_decode (
  input  cce_decode_pkg::cce_inst_t      inst_i,
  output cce_decode_pkg::decode_fields_t fields_o
);

  logic known;

  always_comb begin
    fields_o = '0;
    known    = 1'b1;
    case (inst_i.op)
      cce_decode_pkg::e_op_alu: begin
        case (inst_i.minor_op.alu_minor_op)
          cce_decode_pkg::e_add_op, cce_decode_pkg::e_addi_op:
            fields_o.alu_op = cce_decode_pkg::e_alu_add;
          cce_decode_pkg::e_sub_op, cce_decode_pkg::e_subi_op:
            fields_o.alu_op = cce_decode_pkg::e_alu_sub;
          cce_decode_pkg::e_lsh_op, cce_decode_pkg::e_lshi_op:
            fields_o.alu_op = cce_decode_pkg::e_alu_lsh;
          cce_decode_pkg::e_rsh_op, cce_decode_pkg::e_rshi_op:
            fields_o.alu_op = cce_decode_pkg::e_alu_rsh;
          cce_decode_pkg::e_and_op: fields_o.alu_op = cce_decode_pkg::e_alu_and;
          cce_decode_pkg::e_or_op:  fields_o.alu_op = cce_decode_pkg::e_alu_or;
          cce_decode_pkg::e_xor_op: fields_o.alu_op = cce_decode_pkg::e_alu_xor;
          cce_decode_pkg::e_neg_op: fields_o.alu_op = cce_decode_pkg::e_alu_neg;
          cce_decode_pkg::e_not_op: fields_o.alu_op = cce_decode_pkg::e_alu_not;
          default: known = 1'b0;
        endcase
        // dst sits in the same low field for rtype and itype
        fields_o.dst_sel   = cce_decode_pkg::e_dst_sel_gpr;
        fields_o.dst       = inst_i.type_u.rtype.dst;
        fields_o.src_a_sel = cce_decode_pkg::e_src_sel_gpr;
        fields_o.src_a     = inst_i.type_u.rtype.src_a;
        case (inst_i.minor_op.alu_minor_op)
          cce_decode_pkg::e_addi_op, cce_decode_pkg::e_subi_op,
          cce_decode_pkg::e_lshi_op, cce_decode_pkg::e_rshi_op: begin
            fields_o.src_b_sel = cce_decode_pkg::e_src_sel_imm;
            fields_o.imm       = inst_i.type_u.itype.imm;
          end
          // single operand ops
          cce_decode_pkg::e_neg_op, cce_decode_pkg::e_not_op: begin
          end
          default: begin
            fields_o.src_b_sel = cce_decode_pkg::e_src_sel_gpr;
            fields_o.src_b     = inst_i.type_u.rtype.src_b;
          end
        endcase
      end
      cce_decode_pkg::e_op_reg_data: begin
        fields_o.dst_sel   = cce_decode_pkg::e_dst_sel_gpr;
        fields_o.dst       = inst_i.type_u.rtype.dst;
        fields_o.src_a_sel = cce_decode_pkg::e_src_sel_gpr;
        fields_o.src_a     = inst_i.type_u.rtype.src_a;
        case (inst_i.minor_op.reg_data_minor_op)
          cce_decode_pkg::e_mov_op: begin
          end
          cce_decode_pkg::e_movfg_op: fields_o.src_a_sel = cce_decode_pkg::e_src_sel_flag;
          cce_decode_pkg::e_movgf_op: fields_o.dst_sel = cce_decode_pkg::e_dst_sel_flag;
          cce_decode_pkg::e_movi_op: begin
            fields_o.src_a_sel = cce_decode_pkg::e_src_sel_imm;
            fields_o.src_a     = '0;
            fields_o.imm       = inst_i.type_u.itype.imm;
          end
          default: known = 1'b0;
        endcase
      end
      cce_decode_pkg::e_op_flag: begin
        // flag logic results land in a gpr
        fields_o.dst_sel   = cce_decode_pkg::e_dst_sel_gpr;
        fields_o.dst       = inst_i.type_u.rtype.dst;
        fields_o.src_a_sel = cce_decode_pkg::e_src_sel_flag;
        fields_o.src_a     = inst_i.type_u.rtype.src_a;
        fields_o.src_b_sel = cce_decode_pkg::e_src_sel_flag;
        fields_o.src_b     = inst_i.type_u.rtype.src_b;
        case (inst_i.minor_op.flag_minor_op)
          cce_decode_pkg::e_andf_op: fields_o.alu_op = cce_decode_pkg::e_alu_and;
          cce_decode_pkg::e_orf_op:  fields_o.alu_op = cce_decode_pkg::e_alu_or;
          cce_decode_pkg::e_nandf_op: fields_o.alu_op = cce_decode_pkg::e_alu_nand;
          cce_decode_pkg::e_norf_op: fields_o.alu_op = cce_decode_pkg::e_alu_nor;
          cce_decode_pkg::e_notf_op: begin
            fields_o.alu_op    = cce_decode_pkg::e_alu_not;
            fields_o.src_b_sel = cce_decode_pkg::e_src_sel_none;
            fields_o.src_b     = '0;
          end
          cce_decode_pkg::e_sf_op: begin
            // set flag from imm with the flag index in itype dst
            fields_o          = '0;
            fields_o.src_a_sel = cce_decode_pkg::e_src_sel_imm;
            fields_o.imm       = inst_i.type_u.itype.imm;
            fields_o.dst_sel   = cce_decode_pkg::e_dst_sel_flag;
            fields_o.dst       = inst_i.type_u.itype.dst;
          end
          // flag branches belong to the branch decoder
          default: known = 1'b0;
        endcase
      end
      default: known = 1'b0;
    endcase
    if (!known) begin
      fields_o = '0;
    end
  end

endmodule

// ==== src/cce_branch_decode.sv ====
`include "cce_decode_config.svh"

module cce_branch_decode (
  input  cce_decode_pkg::cce_inst_t      inst_i,
  output cce_decode_pkg::decode_fields_t fields_o
);

  logic known;

  always_comb begin
    fields_o = '0;
    known    = 1'b1;
    case (inst_i.op)
      cce_decode_pkg::e_op_branch: begin
        // target is in the same place for btype and bitype
        fields_o.branch_target = inst_i.type_u.btype.target;
        fields_o.src_a_sel     = cce_decode_pkg::e_src_sel_gpr;
        fields_o.src_a         = inst_i.type_u.btype.src_a;
        fields_o.src_b_sel     = cce_decode_pkg::e_src_sel_gpr;
        fields_o.src_b         = inst_i.type_u.btype.src_b;
        case (inst_i.minor_op.branch_minor_op)
          cce_decode_pkg::e_beq_op: fields_o.branch_op = cce_decode_pkg::e_branch_eq;
          cce_decode_pkg::e_bne_op: fields_o.branch_op = cce_decode_pkg::e_branch_neq;
          cce_decode_pkg::e_blt_op: fields_o.branch_op = cce_decode_pkg::e_branch_lt;
          cce_decode_pkg::e_ble_op: fields_o.branch_op = cce_decode_pkg::e_branch_le;
          cce_decode_pkg::e_beqi_op: begin
            // gpr against imm8
            fields_o.branch_op = cce_decode_pkg::e_branch_eq;
            fields_o.src_b_sel = cce_decode_pkg::e_src_sel_imm;
            fields_o.src_b     = '0;
            fields_o.imm[0+:`CCE_IMM8_WIDTH] = inst_i.type_u.bitype.imm;
          end
          default: known = 1'b0;
        endcase
      end
      cce_decode_pkg::e_op_flag: begin
        // flag branches compare the masked flags against imm or zero
        fields_o.branch_target = inst_i.type_u.bftype.target;
        fields_o.src_a_sel     = cce_decode_pkg::e_src_sel_flags_mask;
        fields_o.imm[0+:cce_decode_pkg::bf_imm_width_lp] = inst_i.type_u.bftype.imm;
        case (inst_i.minor_op.flag_minor_op)
          cce_decode_pkg::e_bf_op: begin
            fields_o.branch_op = cce_decode_pkg::e_branch_eq;
            fields_o.src_b_sel = cce_decode_pkg::e_src_sel_imm;
          end
          cce_decode_pkg::e_bfz_op: begin
            fields_o.branch_op = cce_decode_pkg::e_branch_eq;
            fields_o.src_b_sel = cce_decode_pkg::e_src_sel_zero;
          end
          cce_decode_pkg::e_bfnz_op: begin
            fields_o.branch_op = cce_decode_pkg::e_branch_neq;
            fields_o.src_b_sel = cce_decode_pkg::e_src_sel_zero;
          end
          cce_decode_pkg::e_bfnot_op: begin
            fields_o.branch_op = cce_decode_pkg::e_branch_neq;
            fields_o.src_b_sel = cce_decode_pkg::e_src_sel_imm;
          end
          // flag logic ops go through the alu decoder
          default: known = 1'b0;
        endcase
      end
      default: known = 1'b0;
    endcase
    if (!known) begin
      fields_o = '0;
    end
  end

endmodule

// ==== src/cce_decode_output.sv ====
`include "cce_decode_config.svh"

module cce_decode_output (
  input  cce_decode_pkg::cce_inst_t      inst_i,
  input  logic                           inst_v_i,
  input  cce_decode_pkg::decode_fields_t alu_fields_i,
  input  cce_decode_pkg::decode_fields_t branch_fields_i,
  output cce_decode_pkg::decoded_inst_t  decoded_inst_o
);

  localparam int flag_sel_width_lp = $clog2(`CCE_FLAG_NUM);

  cce_decode_pkg::decode_fields_t fields;
  logic                           gpr_dst;
  logic                           flag_dst;

  // each decoder is all zero outside its own class, so OR is a clean merge
  assign fields = alu_fields_i | branch_fields_i;

  assign gpr_dst  = (fields.dst_sel == cce_decode_pkg::e_dst_sel_gpr);
  assign flag_dst = (fields.dst_sel == cce_decode_pkg::e_dst_sel_flag);

  always_comb begin
    decoded_inst_o = '0;
    // a squashed or empty slot decodes to nothing
    if (inst_v_i) begin
      decoded_inst_o.v             = 1'b1;
      decoded_inst_o.branch        = inst_i.branch;
      decoded_inst_o.predict_taken = inst_i.predict_taken;
      decoded_inst_o.op            = inst_i.op;
      decoded_inst_o.fields        = fields;
      // one-hot write enables from the low bits of dst
      decoded_inst_o.gpr_w_v[fields.dst[`CCE_GPR_SEL_WIDTH-1:0]] = gpr_dst;
      decoded_inst_o.flag_w_v[fields.dst[flag_sel_width_lp-1:0]] = flag_dst;
    end
  end

endmodule

// ==== src/cce_inst_decode.sv ====
`include "cce_decode_config.svh"

module cce_inst_decode (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  cce_decode_pkg::cce_inst_t     inst_i,
  input  logic [`CCE_PC_WIDTH-1:0]      pc_i,
  input  logic                          inst_v_i,
  input  logic                          stall_i,
  input  logic                          mispredict_i,
  output cce_decode_pkg::decoded_inst_t decoded_inst_o,
  output logic [`CCE_PC_WIDTH-1:0]      pc_o
);

  // execute stage instruction and valid bit
  cce_decode_pkg::cce_inst_t      inst_r;
  logic                           inst_v_r;

  // per-class decode results
  cce_decode_pkg::decode_fields_t alu_fields;
  cce_decode_pkg::decode_fields_t branch_fields;

  cce_inst_stage i_cce_inst_stage (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .inst_v_i     (inst_v_i),
    .stall_i      (stall_i),
    .mispredict_i (mispredict_i),
    .inst_o       (inst_r),
    .pc_o         (pc_o),
    .inst_v_o     (inst_v_r)
  );

  cce_alu_mov_decode i_cce_alu_mov_decode (
    .inst_i   (inst_r),
    .fields_o (alu_fields)
  );

  cce_branch_decode i_cce_branch_decode (
    .inst_i   (inst_r),
    .fields_o (branch_fields)
  );

  // only the output side looks at the valid bit
  cce_decode_output i_cce_decode_output (
    .inst_i          (inst_r),
    .inst_v_i        (inst_v_r),
    .alu_fields_i    (alu_fields),
    .branch_fields_i (branch_fields),
    .decoded_inst_o  (decoded_inst_o)
  );

endmodule

// ==== tb/cce_decode_chk.sv ====
`include "cce_decode_config.svh"

module cce_decode_chk (
  input logic                          clk_i,
  input logic                          reset_i,
  input cce_decode_pkg::cce_inst_t     inst_i,
  input logic [`CCE_PC_WIDTH-1:0]      pc_i,
  input logic                          inst_v_i,
  input logic                          stall_i,
  input logic                          mispredict_i,
  input cce_decode_pkg::decoded_inst_t decoded_inst_i,
  input logic [`CCE_PC_WIDTH-1:0]      dut_pc_i
);

  int fail_cnt = 0;

  // reference copy of the stage register
  logic [`CCE_INST_WIDTH-1:0]    word_r;
  logic [`CCE_PC_WIDTH-1:0]      pc_r;
  logic                          v_r;
  cce_decode_pkg::decoded_inst_t exp_inst;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      word_r <= '0;
      pc_r   <= '0;
      v_r    <= 1'b0;
    end else if (!stall_i) begin
      word_r <= inst_i;
      pc_r   <= pc_i;
      v_r    <= inst_v_i && !mispredict_i;
    end
  end

  // raw layout: op 31:29, minor 28:25, branch 24, predict_taken 23, format 22:0
  function automatic cce_decode_pkg::decoded_inst_t model_decode(
    input logic [`CCE_INST_WIDTH-1:0] w,
    input logic                       v
  );
    cce_decode_pkg::decoded_inst_t  d;
    cce_decode_pkg::decode_fields_t f;
    logic [3:0]                     mn;
    logic                           known;
    d     = '0;
    f     = '0;
    mn    = w[28:25];
    known = 1'b0;
    case (w[31:29])
      3'd0: begin
        // 0-3 and 8-11 share add/sub/lsh/rsh, 8-11 take imm16
        known       = (mn <= 4'd12);
        f.dst_sel   = cce_decode_pkg::e_dst_sel_gpr;
        f.dst       = w[3:0];
        f.src_a_sel = cce_decode_pkg::e_src_sel_gpr;
        f.src_a     = w[7:4];
        case (mn)
          4'd4:    f.alu_op = cce_decode_pkg::e_alu_and;
          4'd5:    f.alu_op = cce_decode_pkg::e_alu_or;
          4'd6:    f.alu_op = cce_decode_pkg::e_alu_xor;
          4'd7:    f.alu_op = cce_decode_pkg::e_alu_neg;
          4'd12:   f.alu_op = cce_decode_pkg::e_alu_not;
          default: f.alu_op = cce_decode_pkg::alu_op_e'({2'b00, mn[1:0]});
        endcase
        if (mn >= 4'd8 && mn <= 4'd11) begin
          f.src_b_sel = cce_decode_pkg::e_src_sel_imm;
          f.imm       = w[19:4];
        end else if (mn != 4'd7 && mn != 4'd12) begin
          f.src_b_sel = cce_decode_pkg::e_src_sel_gpr;
          f.src_b     = w[11:8];
        end
      end
      3'd1: begin
        known           = (mn <= 4'd4);
        f.branch_target = w[22:15];
        f.src_a_sel     = cce_decode_pkg::e_src_sel_gpr;
        f.src_a         = w[3:0];
        if (mn == 4'd4) begin
          f.src_b_sel = cce_decode_pkg::e_src_sel_imm;
          f.imm       = {8'h00, w[11:4]};
        end else begin
          f.branch_op = cce_decode_pkg::branch_op_e'(mn[1:0]);
          f.src_b_sel = cce_decode_pkg::e_src_sel_gpr;
          f.src_b     = w[7:4];
        end
      end
      3'd2: begin
        known     = (mn <= 4'd3);
        f.dst     = w[3:0];
        f.dst_sel = (mn == 4'd2) ? cce_decode_pkg::e_dst_sel_flag : cce_decode_pkg::e_dst_sel_gpr;
        f.src_a_sel = (mn == 4'd1) ? cce_decode_pkg::e_src_sel_flag :
                      (mn == 4'd3) ? cce_decode_pkg::e_src_sel_imm : cce_decode_pkg::e_src_sel_gpr;
        if (mn == 4'd3) begin
          f.imm = w[19:4];
        end else begin
          f.src_a = w[7:4];
        end
      end
      3'd3: begin
        known = (mn <= 4'd9);
        if (mn == 4'd0) begin
          f.src_a_sel = cce_decode_pkg::e_src_sel_imm;
          f.imm       = w[19:4];
          f.dst_sel   = cce_decode_pkg::e_dst_sel_flag;
          f.dst       = w[3:0];
        end else if (mn <= 4'd5) begin
          f.dst_sel   = cce_decode_pkg::e_dst_sel_gpr;
          f.dst       = w[3:0];
          f.src_a_sel = cce_decode_pkg::e_src_sel_flag;
          f.src_a     = w[7:4];
          case (mn)
            4'd1:    f.alu_op = cce_decode_pkg::e_alu_and;
            4'd2:    f.alu_op = cce_decode_pkg::e_alu_or;
            4'd3:    f.alu_op = cce_decode_pkg::e_alu_nand;
            4'd4:    f.alu_op = cce_decode_pkg::e_alu_nor;
            default: f.alu_op = cce_decode_pkg::e_alu_not;
          endcase
          if (mn != 4'd5) begin
            f.src_b_sel = cce_decode_pkg::e_src_sel_flag;
            f.src_b     = w[11:8];
          end
        end else begin
          // flag branches, mask is 15 bits wide
          f.branch_target = w[22:15];
          f.src_a_sel     = cce_decode_pkg::e_src_sel_flags_mask;
          f.imm           = {1'b0, w[14:0]};
          f.branch_op = (mn <= 4'd7) ? cce_decode_pkg::e_branch_eq : cce_decode_pkg::e_branch_neq;
          f.src_b_sel = (mn == 4'd7 || mn == 4'd8) ? cce_decode_pkg::e_src_sel_zero :
                        cce_decode_pkg::e_src_sel_imm;
        end
      end
      default: known = 1'b0;
    endcase
    if (v) begin
      d.v             = 1'b1;
      d.branch        = w[24];
      d.predict_taken = w[23];
      d.op            = cce_decode_pkg::op_e'(w[31:29]);
      if (known) begin
        d.fields = f;
        for (int i = 0; i < `CCE_GPR_NUM; i++) begin
          d.gpr_w_v[i]  = (f.dst_sel == cce_decode_pkg::e_dst_sel_gpr) && (f.dst[2:0] == i[2:0]);
          d.flag_w_v[i] = (f.dst_sel == cce_decode_pkg::e_dst_sel_flag) && (f.dst[2:0] == i[2:0]);
        end
      end
    end
    return d;
  endfunction

  assign exp_inst = model_decode(word_r, v_r);

  a_header: assert property (@(posedge clk_i) disable iff (reset_i)
    {decoded_inst_i.v, decoded_inst_i.branch, decoded_inst_i.predict_taken, decoded_inst_i.op} ==
    {exp_inst.v, exp_inst.branch, exp_inst.predict_taken, exp_inst.op})
    else begin
      fail_cnt++;
      $error("CHECK FAILED decoded_inst_o v/hints/op got %h exp %h",
        $sampled({decoded_inst_i.v, decoded_inst_i.branch, decoded_inst_i.predict_taken,
                  decoded_inst_i.op}),
        $sampled({exp_inst.v, exp_inst.branch, exp_inst.predict_taken, exp_inst.op}));
    end

  a_fields: assert property (@(posedge clk_i) disable iff (reset_i)
    decoded_inst_i.fields == exp_inst.fields)
    else begin
      fail_cnt++;
      $error("CHECK FAILED decoded_inst_o.fields got %h exp %h",
        $sampled(decoded_inst_i.fields), $sampled(exp_inst.fields));
    end

  a_write_en: assert property (@(posedge clk_i) disable iff (reset_i)
    {decoded_inst_i.gpr_w_v, decoded_inst_i.flag_w_v} == {exp_inst.gpr_w_v, exp_inst.flag_w_v})
    else begin
      fail_cnt++;
      $error("CHECK FAILED gpr_w_v/flag_w_v got %h exp %h",
        $sampled({decoded_inst_i.gpr_w_v, decoded_inst_i.flag_w_v}),
        $sampled({exp_inst.gpr_w_v, exp_inst.flag_w_v}));
    end

  a_pc: assert property (@(posedge clk_i) disable iff (reset_i) dut_pc_i == pc_r)
    else begin
      fail_cnt++;
      $error("CHECK FAILED pc_o got %h exp %h", $sampled(dut_pc_i), $sampled(pc_r));
    end

  a_stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    stall_i |=> $stable(decoded_inst_i) && $stable(dut_pc_i))
    else begin
      fail_cnt++;
      $error("outputs changed while stalled, decoded_inst_o %h pc_o %h",
        $sampled(decoded_inst_i), $sampled(dut_pc_i));
    end

  a_squash: assert property (@(posedge clk_i) disable iff (reset_i)
    !stall_i && mispredict_i |=> decoded_inst_i == '0)
    else begin
      fail_cnt++;
      $error("CHECK FAILED decoded_inst_o after mispredict got %h exp %h",
        $sampled(decoded_inst_i), 0);
    end

endmodule

bind cce_inst_decode cce_decode_chk i_cce_decode_chk (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .inst_i         (inst_i),
  .pc_i           (pc_i),
  .inst_v_i       (inst_v_i),
  .stall_i        (stall_i),
  .mispredict_i   (mispredict_i),
  .decoded_inst_i (decoded_inst_o),
  .dut_pc_i       (pc_o)
);

// ==== tb/tb_cce_inst_decode.sv ====
`include "cce_decode_config.svh"

module tb_cce_inst_decode;

  // reset 2, idle 9, alu 16, move/flag 13, branch 12, stall 10, squash/unknown 43
  localparam int test_cycles_lp    = 2 + 9 + 16 + 13 + 12 + 10 + 43;
  localparam int timeout_cycles_lp = 2 * test_cycles_lp;

  logic                          clk_i;
  logic                          reset_i;
  cce_decode_pkg::cce_inst_t     inst_i;
  logic [`CCE_PC_WIDTH-1:0]      pc_i;
  logic                          inst_v_i;
  logic                          stall_i;
  logic                          mispredict_i;
  cce_decode_pkg::decoded_inst_t decoded_inst_o;
  logic [`CCE_PC_WIDTH-1:0]      pc_o;

  int cycle_cnt = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int fails_at_start = 0;

  cce_inst_decode i_cce_inst_decode (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .inst_i         (inst_i),
    .pc_i           (pc_i),
    .inst_v_i       (inst_v_i),
    .stall_i        (stall_i),
    .mispredict_i   (mispredict_i),
    .decoded_inst_o (decoded_inst_o),
    .pc_o           (pc_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // one instruction per edge, register fields, hints and pc are random
  task automatic send_inst(input logic [2:0] op, input logic [3:0] minor, input logic v);
    logic [31:0] rnd;
    logic [31:0] rnd_pc;
    rnd    = $urandom();
    rnd_pc = $urandom();
    @(posedge clk_i);
    inst_i   <= {op, minor, rnd[24:0]};
    pc_i     <= rnd_pc[`CCE_PC_WIDTH-1:0];
    inst_v_i <= v;
  endtask

  task automatic start_test();
    fails_at_start = i_cce_inst_decode.i_cce_decode_chk.fail_cnt;
  endtask

  // three edges let the last instruction load, get checked and get counted
  task automatic end_test(input string name);
    int errors;
    @(posedge clk_i);
    inst_v_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    errors = i_cce_inst_decode.i_cce_decode_chk.fail_cnt - fails_at_start;
    tests_run++;
    if (errors == 0) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d check failures", name, errors);
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles_lp) begin
      $display("timeout: tests did not finish within %0d cycles", timeout_cycles_lp);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(99163));
    reset_i      = 1'b1;
    inst_i       = '0;
    pc_i         = '0;
    inst_v_i     = 1'b0;
    stall_i      = 1'b0;
    mispredict_i = 1'b0;
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    start_test();
    repeat (6) begin
      @(posedge clk_i);
      inst_i   <= $urandom();
      inst_v_i <= 1'b0;
      pc_i     <= '0;
    end
    end_test("reset_idle");

    start_test();
    for (int m = 0; m <= 12; m++) send_inst(3'd0, m[3:0], 1'b1);
    end_test("alu_ops");

    start_test();
    for (int m = 0; m <= 3; m++) send_inst(3'd2, m[3:0], 1'b1);
    for (int m = 0; m <= 5; m++) send_inst(3'd3, m[3:0], 1'b1);
    end_test("move_flag_ops");

    start_test();
    for (int m = 0; m <= 4; m++) send_inst(3'd1, m[3:0], 1'b1);
    for (int m = 6; m <= 9; m++) send_inst(3'd3, m[3:0], 1'b1);
    end_test("branch_ops");

    // inputs keep changing while the stage holds its instruction
    start_test();
    send_inst(3'd0, 4'd0, 1'b1);
    repeat (5) begin
      send_inst(3'd1, 4'd1, 1'b1);
      stall_i <= 1'b1;
    end
    @(posedge clk_i);
    stall_i <= 1'b0;
    end_test("stall_hold");

    start_test();
    repeat (2) begin
      send_inst(3'd0, 4'd1, 1'b1);
      mispredict_i <= 1'b1;
      send_inst(3'd2, 4'd0, 1'b1);
      mispredict_i <= 1'b0;
    end
    for (int m = 13; m <= 15; m++) send_inst(3'd0, m[3:0], 1'b1);
    for (int m = 5; m <= 15; m++) send_inst(3'd1, m[3:0], 1'b1);
    for (int m = 4; m <= 15; m++) send_inst(3'd2, m[3:0], 1'b1);
    for (int m = 10; m <= 15; m++) send_inst(3'd3, m[3:0], 1'b1);
    for (int o = 4; o <= 7; o++) send_inst(o[2:0], 4'd0, 1'b1);
    end_test("squash_unknown");

    $display("tests run %0d, tests failed %0d, check failures %0d",
      tests_run, tests_failed, i_cce_inst_decode.i_cce_decode_chk.fail_cnt);
    if (tests_failed == 0 && i_cce_inst_decode.i_cce_decode_chk.fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
src/cce_decode_pkg.sv
src/cce_inst_stage.sv
src/cce_alu_mov_decode.sv
src/cce_branch_decode.sv
src/cce_decode_output.sv
src/cce_inst_decode.sv
tb/cce_decode_chk.sv
tb/tb_cce_inst_decode.sv
